/* build.f */
+incdir+common
common/cache_pkg.sv
verilog/tag_store.sv
verilog/data_store.sv
miss_ctrl/miss_ctrl.sv
verilog/cache_top.sv
dv/mem_model.sv
dv/cache_chk.sv
dv/tb_cache_top.sv

/* common/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// ----------------------------------------------------------------------
// address and data widths
// ----------------------------------------------------------------------
`define ADDR_W      16
`define DATA_W      32

// 16 lines of one word each
`define INDEX_W     4
`define OFFSET_W    2
`define TAG_W       (`ADDR_W - `INDEX_W - `OFFSET_W)
`define LINES       (1 << `INDEX_W)

// ----------------------------------------------------------------------
// memory port flow control
// ----------------------------------------------------------------------
// requests the memory can take before it returns a credit
`define MEM_CREDITS 2
`define CREDIT_W    2

`endif

/* common/cache_pkg.sv */
`include "cache_params.svh"

package cache_pkg;

    // ------------------------------------------------------------------
    // vectors with a meaning
    // ------------------------------------------------------------------
    typedef logic [`ADDR_W-1:0]   addr_t;
    typedef logic [`DATA_W-1:0]   data_t;
    typedef logic [`INDEX_W-1:0]  index_t;
    typedef logic [`TAG_W-1:0]    tag_t;
    typedef logic [`CREDIT_W-1:0] credit_t;

    // ------------------------------------------------------------------
    // port bundles
    // ------------------------------------------------------------------
    typedef struct packed {
        logic  valid;
        logic  we;
        addr_t addr;
        data_t wdata;
    } cpu_req_t;

    // store responses echo the written word
    typedef struct packed {
        logic  valid;
        logic  hit;
        data_t rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic  valid;
        logic  we;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        data_t rdata;
    } mem_rsp_t;

    // registered tag lookup, victim fields describe the indexed line
    typedef struct packed {
        logic hit;
        logic victim_valid;
        logic victim_dirty;
        tag_t victim_tag;
    } lookup_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL_REQ,
        ST_REFILL_WAIT,
        ST_RESPOND
    } ctrl_state_e;

endpackage

/* dv/cache_chk.sv */
`timescale 1ns/1ps

`include "cache_params.svh"

module cache_chk import cache_pkg::*; (
    input logic     clk,
    input logic     reset,
    input mem_req_t mem_req,
    input logic     mem_credit,
    input credit_t  credits_q,
    input cpu_rsp_t cpu_rsp
);

    // credits rebuilt from the port traffic alone
    int port_credits;

    always_ff @(posedge clk) begin
        if (reset) begin
            port_credits <= `MEM_CREDITS;
        end else begin
            port_credits <= port_credits + int'(mem_credit) - int'(mem_req.valid);
        end
    end

    // ------------------------------------------------------------------
    // memory credits
    // ------------------------------------------------------------------
    a_req_needs_credit: assert property (
        @(posedge clk) disable iff (reset) mem_req.valid |-> (port_credits > 0)
    ) else $error("memory request sent with no credit left");

    a_credit_limit: assert property (
        @(posedge clk) disable iff (reset) credits_q <= credit_t'(`MEM_CREDITS)
    ) else $error("credit count above the memory limit");

    // response is a single cycle pulse
    a_rsp_one_cycle: assert property (
        @(posedge clk) disable iff (reset) cpu_rsp.valid |=> !cpu_rsp.valid
    ) else $error("cpu_rsp valid held for more than one cycle");

endmodule

bind miss_ctrl cache_chk u_cache_chk (
    .clk        (clk),
    .reset      (reset),
    .mem_req    (mem_req),
    .mem_credit (mem_credit),
    .credits_q  (credits_q),
    .cpu_rsp    (cpu_rsp)
);

/* dv/cache_input.txt */
# op addr wdata hit rdata nreq, all hex except nreq in decimal
# wback lines check the last memory write, their hit rdata nreq are unused
load  0010 00000000 0 0010ffef 1
load  0010 00000000 1 0010ffef 0
store 0010 cafe0001 1 cafe0001 0
load  0010 00000000 1 cafe0001 0
load  0050 00000000 0 0050ffaf 2
wback 0010 cafe0001 0 00000000 0
load  0050 00000000 1 0050ffaf 0
# index 8 store miss then a conflicting load
store 0020 11112222 0 11112222 0
load  0060 00000000 0 0060ff9f 2
wback 0020 11112222 0 00000000 0
load  0020 00000000 0 11112222 1
load  0020 00000000 1 11112222 0
# store miss into an unused line
store 0034 a5a55a5a 0 a5a55a5a 0
load  0034 00000000 1 a5a55a5a 0
# back to back conflicts on index 1
store 0004 01234567 0 01234567 0
store 0044 89abcdef 0 89abcdef 1
wback 0004 01234567 0 00000000 0
load  0004 00000000 0 01234567 2
wback 0044 89abcdef 0 00000000 0
load  0044 00000000 0 89abcdef 1
load  00c4 00000000 0 00c4ff3b 1
# index 4 again, store over a clean line
store 0010 0badf00d 0 0badf00d 0
load  0050 00000000 0 0050ffaf 2
wback 0010 0badf00d 0 00000000 0
load  0010 00000000 0 0badf00d 1
load  00fc 00000000 0 00fcff03 1
load  00fc 00000000 1 00fcff03 0
load  0034 00000000 1 a5a55a5a 0

/* dv/mem_model.sv */
`timescale 1ns/1ps

module mem_model import cache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  mem_req_t mem_req,
    output logic     mem_credit,
    output mem_rsp_t mem_rsp
);

    data_t       mem [64];
    logic [31:0] lfsr;
    logic [2:0]  delay;
    int          idx;

    // one entry per consumed request, retired in order
    int          delay_q [$];
    bit          read_q [$];
    data_t       data_q [$];

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    initial begin
        mem_credit = 1'b0;
        mem_rsp    = '0;
        lfsr       = 32'h0cf5cc28;
        // address in the upper half, its inverse below
        for (idx = 0; idx < 64; idx++) begin
            mem[idx] = {16'(idx * 4), ~16'(idx * 4)};
        end
        forever begin
            // ----------------------------------------------------------
            // drive credit and read data after the edge
            // ----------------------------------------------------------
            @(posedge clk);
            #1;
            mem_credit = 1'b0;
            mem_rsp    = '0;
            if (delay_q.size() > 0) begin
                if (delay_q[0] == 0) begin
                    mem_credit = 1'b1;
                    if (read_q[0]) begin
                        mem_rsp.valid = 1'b1;
                        mem_rsp.rdata = data_q[0];
                    end
                    delay_q.delete(0);
                    read_q.delete(0);
                    data_q.delete(0);
                end else begin
                    delay_q[0] = delay_q[0] - 1;
                end
            end
            // ----------------------------------------------------------
            // take the request that the next edge consumes
            // ----------------------------------------------------------
            @(negedge clk);
            if (!reset && mem_req.valid) begin
                delay = '0;
                repeat (3) begin
                    lfsr  = lfsr_step(lfsr);
                    delay = {delay[1:0], lfsr[0]};
                end
                delay_q.push_back(int'(delay));
                read_q.push_back(!mem_req.we);
                if (mem_req.we) begin
                    mem[mem_req.addr[7:2]] = mem_req.wdata;
                    data_q.push_back('0);
                end else begin
                    data_q.push_back(mem[mem_req.addr[7:2]]);
                end
            end
        end
    end

endmodule

/* dv/tb_cache_top.sv */
`timescale 1ns/1ps

module tb_cache_top import cache_pkg::*; ();

    localparam int TIMEOUT_CYCLES  = 200;
    localparam int MAX_OUTSTANDING = 2;

    logic     clk;
    logic     reset;
    cpu_req_t cpu_req;
    logic     cpu_ready;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    logic     mem_credit;
    mem_rsp_t mem_rsp;

    int    errors       = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    int    sent_count   = 0;
    int    credit_count = 0;
    bit    stop         = 1'b0;
    addr_t last_wb_addr = '0;
    data_t last_wb_data = '0;

    // file reading
    int                fd;
    int                fields;
    int                ops_read;
    int                err_before;
    int                cycles;
    logic [8*96-1:0]   line;
    string             op;
    addr_t             addr;
    data_t             wdata;
    data_t             exp_hit;
    data_t             exp_rdata;
    int                exp_nreq;

    cache_top UUT (
        .clk        (clk),
        .reset      (reset),
        .cpu_req    (cpu_req),
        .cpu_ready  (cpu_ready),
        .cpu_rsp    (cpu_rsp),
        .mem_req    (mem_req),
        .mem_credit (mem_credit),
        .mem_rsp    (mem_rsp)
    );

    mem_model u_mem (
        .clk        (clk),
        .reset      (reset),
        .mem_req    (mem_req),
        .mem_credit (mem_credit),
        .mem_rsp    (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // ------------------------------------------------------------------
    // memory port monitor, requests against returned credits
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        if (!reset) begin
            if (mem_req.valid) begin
                sent_count++;
                if (mem_req.we) begin
                    last_wb_addr = mem_req.addr;
                    last_wb_data = mem_req.wdata;
                end
            end
            if (mem_credit) begin
                credit_count++;
            end
            if (sent_count - credit_count > MAX_OUTSTANDING) begin
                $display("too many memory requests outstanding: %0d",
                         sent_count - credit_count);
                errors++;
            end
            if (credit_count > sent_count) begin
                $display("memory returned a credit with no request open");
                errors++;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string what, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %0d %s: ok", tests_run, what);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, what);
        end
    endtask

    task automatic wait_ready(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < TIMEOUT_CYCLES; n++) begin
            @(negedge clk);
            if (cpu_ready) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    task automatic wait_response(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < TIMEOUT_CYCLES; n++) begin
            @(negedge clk);
            if (cpu_rsp.valid) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    // one cpu load or store, held until accepted
    task automatic run_op(input string kind, input addr_t a, input data_t wd,
                          input data_t hit_exp, input data_t data_exp, input int nreq_exp);
        int sent_before;
        bit ok;
        sent_before = sent_count;
        @(posedge clk);
        #1;
        cpu_req.valid = 1'b1;
        cpu_req.we    = (kind == "store");
        cpu_req.addr  = a;
        cpu_req.wdata = wd;
        wait_ready(ok);
        if (!ok) begin
            $display("timeout, cpu_ready never rose for %s %h", kind, a);
            errors++;
            stop = 1'b1;
        end else begin
            @(posedge clk);
            #1;
            cpu_req = '0;
            wait_response(ok);
            if (!ok) begin
                $display("timeout, no cpu response for %s %h", kind, a);
                errors++;
                stop = 1'b1;
            end else begin
                check_value("cpu_rsp.hit", 32'(cpu_rsp.hit), hit_exp);
                check_value("cpu_rsp.rdata", cpu_rsp.rdata, data_exp);
                check_value("mem_req count", 32'(sent_count - sent_before), 32'(nreq_exp));
            end
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        reset    = 1'b1;
        cpu_req  = '0;
        ops_read = 0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        @(negedge clk);
        err_before = errors;
        check_value("cpu_ready", 32'(cpu_ready), 32'h1);
        check_value("cpu_rsp.valid", 32'(cpu_rsp.valid), 32'h0);
        check_value("mem_req.valid", 32'(mem_req.valid), 32'h0);
        report_test("reset state", err_before);

        fd = $fopen("dv/cache_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the input file dv/cache_input.txt");
            errors++;
        end else begin
            while (!stop && $fgets(line, fd) != 0) begin
                // comment and blank lines do not scan to six fields
                fields = $sscanf(line, "%s %h %h %h %h %d",
                                 op, addr, wdata, exp_hit, exp_rdata, exp_nreq);
                if (fields == 6) begin
                    ops_read++;
                    err_before = errors;
                    if (op == "wback") begin
                        check_value("mem_req.addr", 32'(last_wb_addr), 32'(addr));
                        check_value("mem_req.wdata", last_wb_data, wdata);
                    end else if (op == "load" || op == "store") begin
                        run_op(op, addr, wdata, exp_hit, exp_rdata, exp_nreq);
                    end else begin
                        $display("unknown operation %s in the input file", op);
                        errors++;
                    end
                    report_test($sformatf("%s %h", op, addr), err_before);
                end
            end
            $fclose(fd);
            if (ops_read == 0) begin
                $display("no operations found in the input file");
                errors++;
            end
        end

        // every request must get its credit back
        cycles = 0;
        while (credit_count != sent_count && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (credit_count != sent_count) begin
            $display("%0d memory credits never came back", sent_count - credit_count);
            errors++;
        end

        $display("tests %0d, passed %0d, failed %0d, requests %0d, credits %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed,
                 sent_count, credit_count, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* miss_ctrl/miss_ctrl.sv */
`timescale 1ns/1ps

`include "cache_params.svh"

module miss_ctrl import cache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  cpu_req_t cpu_req,
    output logic     cpu_ready,
    output cpu_rsp_t cpu_rsp,
    output logic     lookup_en,
    output index_t   lookup_index,
    output tag_t     lookup_tag,
    input  lookup_t  lookup,
    input  data_t    rd_data,
    output logic     tag_we,
    output index_t   tag_wr_index,
    output tag_t     tag_wr_tag,
    output logic     tag_wr_dirty,
    output logic     wr_en,
    output index_t   wr_index,
    output data_t    wr_data,
    output mem_req_t mem_req,
    input  logic     mem_credit,
    input  mem_rsp_t mem_rsp
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    cpu_req_t    req_q;
    cpu_rsp_t    rsp_q;
    logic        rsp_hit_d;
    data_t       rsp_data_d;
    credit_t     credits_q;
    logic        credit_avail;
    index_t      req_index;
    tag_t        req_tag;
    addr_t       victim_addr;
    addr_t       line_addr;

    // ------------------------------------------------------------------
    // request capture and lookup strobe
    // ------------------------------------------------------------------
    assign cpu_ready    = (state_q == ST_IDLE);
    assign lookup_en    = cpu_ready && cpu_req.valid;
    assign lookup_index = cpu_req.addr[`OFFSET_W +: `INDEX_W];
    assign lookup_tag   = cpu_req.addr[`OFFSET_W + `INDEX_W +: `TAG_W];

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            req_q <= cpu_req;
        end
    end

    assign req_index   = req_q.addr[`OFFSET_W +: `INDEX_W];
    assign req_tag     = req_q.addr[`OFFSET_W + `INDEX_W +: `TAG_W];
    assign line_addr   = {req_tag, req_index, {`OFFSET_W{1'b0}}};
    assign victim_addr = {lookup.victim_tag, req_index, {`OFFSET_W{1'b0}}};

    // both write ports always target the open request's line
    assign tag_wr_index = req_index;
    assign tag_wr_tag   = req_tag;
    assign wr_index     = req_index;

    assign credit_avail = (credits_q != '0);

    // ------------------------------------------------------------------
    // next state, store writes and memory requests
    // ------------------------------------------------------------------
    always_comb begin
        state_d      = state_q;
        rsp_hit_d    = rsp_q.hit;
        rsp_data_d   = rsp_q.rdata;
        tag_we       = 1'b0;
        tag_wr_dirty = 1'b0;
        wr_en        = 1'b0;
        wr_data      = req_q.wdata;
        mem_req      = '0;
        case (state_q)
            ST_IDLE: begin
                if (cpu_req.valid) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (lookup.hit || (req_q.we && !(lookup.victim_valid && lookup.victim_dirty))) begin
                    // hit, or store miss over a clean line
                    rsp_hit_d = lookup.hit;
                    if (req_q.we) begin
                        tag_we       = 1'b1;
                        tag_wr_dirty = 1'b1;
                        wr_en        = 1'b1;
                        rsp_data_d   = req_q.wdata;
                    end else begin
                        rsp_data_d = rd_data;
                    end
                    state_d = ST_RESPOND;
                end else if (lookup.victim_valid && lookup.victim_dirty) begin
                    state_d = ST_WRITEBACK;
                end else begin
                    state_d = ST_REFILL_REQ;
                end
            end
            ST_WRITEBACK: begin
                // old word is still on rd_data from the lookup
                mem_req.valid = credit_avail;
                mem_req.we    = 1'b1;
                mem_req.addr  = victim_addr;
                mem_req.wdata = rd_data;
                if (credit_avail) begin
                    if (req_q.we) begin
                        tag_we       = 1'b1;
                        tag_wr_dirty = 1'b1;
                        wr_en        = 1'b1;
                        rsp_hit_d    = 1'b0;
                        rsp_data_d   = req_q.wdata;
                        state_d      = ST_RESPOND;
                    end else begin
                        state_d = ST_REFILL_REQ;
                    end
                end
            end
            ST_REFILL_REQ: begin
                mem_req.valid = credit_avail;
                mem_req.addr  = line_addr;
                if (credit_avail) begin
                    state_d = ST_REFILL_WAIT;
                end
            end
            ST_REFILL_WAIT: begin
                if (mem_rsp.valid) begin
                    tag_we     = 1'b1;
                    wr_en      = 1'b1;
                    wr_data    = mem_rsp.rdata;
                    rsp_hit_d  = 1'b0;
                    rsp_data_d = mem_rsp.rdata;
                    state_d    = ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // state, credits and response register
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= ST_IDLE;
            credits_q   <= credit_t'(`MEM_CREDITS);
            rsp_q.valid <= 1'b0;
        end else begin
            state_q     <= state_d;
            credits_q   <= credits_q + credit_t'(mem_credit) - credit_t'(mem_req.valid);
            // one pulse, RESPOND always returns to IDLE
            rsp_q.valid <= (state_d == ST_RESPOND);
        end
    end

    always_ff @(posedge clk) begin
        rsp_q.hit   <= rsp_hit_d;
        rsp_q.rdata <= rsp_data_d;
    end

    assign cpu_rsp = rsp_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cache_top -f build.f -Mdir obj_dir -o sim_cache
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_cache > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

echo "simulation passed"
exit 0

/* verilog/cache_top.sv */
`timescale 1ns/1ps

`include "cache_params.svh"

module cache_top import cache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  cpu_req_t cpu_req,
    output logic     cpu_ready,
    output cpu_rsp_t cpu_rsp,
    output mem_req_t mem_req,
    input  logic     mem_credit,
    input  mem_rsp_t mem_rsp
);

    // ------------------------------------------------------------------
    // controller to stores
    // ------------------------------------------------------------------
    logic    lookup_en;
    index_t  lookup_index;
    tag_t    lookup_tag;
    lookup_t lookup;
    data_t   rd_data;

    logic    tag_we;
    index_t  tag_wr_index;
    tag_t    tag_wr_tag;
    logic    tag_wr_dirty;

    logic    wr_en;
    index_t  wr_index;
    data_t   wr_data;

    tag_store u_tag_store (
        .clk          (clk),
        .reset        (reset),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .lookup       (lookup),
        .tag_we       (tag_we),
        .tag_wr_index (tag_wr_index),
        .tag_wr_tag   (tag_wr_tag),
        .tag_wr_dirty (tag_wr_dirty)
    );

    // read side by side with the tags, same strobe and index
    data_store u_data_store (
        .clk      (clk),
        .rd_en    (lookup_en),
        .rd_index (lookup_index),
        .rd_data  (rd_data),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data)
    );

    miss_ctrl u_miss_ctrl (
        .clk          (clk),
        .reset        (reset),
        .cpu_req      (cpu_req),
        .cpu_ready    (cpu_ready),
        .cpu_rsp      (cpu_rsp),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .lookup       (lookup),
        .rd_data      (rd_data),
        .tag_we       (tag_we),
        .tag_wr_index (tag_wr_index),
        .tag_wr_tag   (tag_wr_tag),
        .tag_wr_dirty (tag_wr_dirty),
        .wr_en        (wr_en),
        .wr_index     (wr_index),
        .wr_data      (wr_data),
        .mem_req      (mem_req),
        .mem_credit   (mem_credit),
        .mem_rsp      (mem_rsp)
    );

endmodule

/* verilog/data_store.sv */
`timescale 1ns/1ps

`include "cache_params.svh"

module data_store import cache_pkg::*; (
    input  logic   clk,

    // read port, registered
    input  logic   rd_en,
    input  index_t rd_index,
    output data_t  rd_data,

    // write port
    input  logic   wr_en,
    input  index_t wr_index,
    input  data_t  wr_data
);

    // ------------------------------------------------------------------
    // one word per line
    // ------------------------------------------------------------------
    data_t words [`LINES];
    data_t rd_data_q;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            words[wr_index] <= wr_data;
        end
    end

    // holds until the next strobe, which also keeps the victim word
    // around for a writeback
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data_q <= words[rd_index];
        end
    end

    assign rd_data = rd_data_q;

endmodule

/* verilog/tag_store.sv */
`timescale 1ns/1ps

`include "cache_params.svh"

module tag_store import cache_pkg::*; (
    input  logic    clk,
    input  logic    reset,

    // lookup port, answers one cycle after the strobe
    input  logic    lookup_en,
    input  index_t  lookup_index,
    input  tag_t    lookup_tag,
    output lookup_t lookup,

    // update port
    input  logic    tag_we,
    input  index_t  tag_wr_index,
    input  tag_t    tag_wr_tag,
    input  logic    tag_wr_dirty
);

    // ------------------------------------------------------------------
    // line state
    // ------------------------------------------------------------------
    tag_t             tags [`LINES];
    logic [`LINES-1:0] valid_q;
    logic [`LINES-1:0] dirty_q;

    lookup_t lookup_q;
    logic    tag_match;

    // valid and dirty bits per line
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (tag_we) begin
            valid_q[tag_wr_index] <= 1'b1;
            dirty_q[tag_wr_index] <= tag_wr_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags[tag_wr_index] <= tag_wr_tag;
        end
    end

    // ------------------------------------------------------------------
    // hit compare and victim capture
    // ------------------------------------------------------------------
    assign tag_match = (tags[lookup_index] == lookup_tag);

    // victim fields come from the same indexed entry
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            lookup_q.hit          <= valid_q[lookup_index] && tag_match;
            lookup_q.victim_valid <= valid_q[lookup_index];
            lookup_q.victim_dirty <= dirty_q[lookup_index];
            lookup_q.victim_tag   <= tags[lookup_index];
        end
    end

    assign lookup = lookup_q;

endmodule
